//--- spi_lcd_defs.svh
`ifndef SPI_LCD_DEFS_SVH
`define SPI_LCD_DEFS_SVH

// serial clock polarity and phase.
// mode 0 is cpol 0 with cpha 0, which most panel controllers accept.
`define SPI_CPOL 1'b0  // idle level of sclk.
`define SPI_CPHA 1'b0  // 0 samples on the first edge, 1 on the second.

// system clocks per half period of sclk.
// at 27 MHz a value of 4 gives roughly 3.4 MHz on the wire.
`define SPI_CLK_DIV 4

// queue depths between the pipeline stages.
`define ENTRY_FIFO_DEPTH 4  // host entries waiting for the serializer.
`define BYTE_FIFO_DEPTH 4  // flagged bytes waiting for the spi master.

// the byte fifo only has to cover the gap between two spi bytes.
// the entry fifo is what absorbs host bursts.
// a deeper entry fifo lets a host push a short pixel run
// without watching in_ready on every write.

`endif

//--- lcd_entry_pkg.sv
`default_nettype none

package lcd_entry_pkg;

    // host side view of one display entry.
    // the kind decides both the dc flag and the byte count on the wire.

    typedef enum logic [1:0] {
        KIND_CMD    = 2'd0,  // command byte with dc low.
        KIND_DATA8  = 2'd1,  // single parameter or data byte.
        KIND_DATA16 = 2'd2   // rgb565 pixel word sent high byte first.
    } entry_kind_t;

    // code 2'd3 is never produced by the host.
    // the serializer treats it like a data byte.

    typedef struct packed {
        entry_kind_t kind;     // selects one or two bytes.
        logic [15:0] payload;  // cmd and data8 use bits 7:0 only.
    } lcd_entry_t;

    // a cmd entry with payload 8'h2c starts a memory write on most
    // panel controllers, and a run of data16 entries follows it.

endpackage

`default_nettype wire

//--- spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

    // one byte on its way to the wire.
    // dc travels with the byte so it can never slip against the data.

    typedef struct packed {
        logic       dc;    // 0 for a command, 1 for data.
        logic [7:0] data;  // shifted out msb first.
    } spi_byte_t;

    // pins toward the panel.
    // there is no miso since the panel is never read back.

    typedef struct packed {
        logic cs_n;  // low for the whole byte stream.
        logic sclk;  // rests at the cpol level.
        logic mosi;  // serial data out.
        logic dc;    // data/command select.
    } spi_pins_t;

    // the panel latches dc together with the last data bit.
    // holding dc for the whole byte keeps that sample safe.

endpackage

`default_nettype wire

//--- stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire payload_t in_data,
    input  wire           in_valid,
    output logic          in_ready,
    output payload_t      out_data,
    output logic          out_valid,
    input  wire           out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // circular increment that also works for depths that are not a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));  // low only when full.
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];              // head word straight from storage.
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leaves the fill level alone.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- entry_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module entry_serializer (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire lcd_entry_pkg::lcd_entry_t  in_entry,
    input  wire                             in_valid,
    output logic                            in_ready,
    output spi_bus_pkg::spi_byte_t          out_byte,
    output logic                            out_valid,
    input  wire                             out_ready
);

    lcd_entry_pkg::lcd_entry_t entry_q;  // entry being split into bytes.
    logic busy;            // an entry is held and not fully sent.
    logic second_pending;  // current byte is the high half of a pixel word.
    logic take_entry;
    logic byte_done;
    logic is_cmd;
    logic is_word;

    assign take_entry = in_valid && in_ready;
    assign byte_done  = out_valid && out_ready;

    assign is_cmd  = (entry_q.kind == lcd_entry_pkg::KIND_CMD);
    assign is_word = (in_entry.kind == lcd_entry_pkg::KIND_DATA16);

    // a new entry is only taken once the last byte of the old one has left.
    assign in_ready  = !busy;
    assign out_valid = busy;

    // high byte first for pixel words, otherwise the low byte alone.
    always_comb begin
        out_byte.dc = !is_cmd;
        if (second_pending) begin
            out_byte.data = entry_q.payload[15:8];
        end else begin
            out_byte.data = entry_q.payload[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (take_entry) begin
            entry_q <= in_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            second_pending <= 1'b0;
        end else if (take_entry) begin
            busy           <= 1'b1;
            second_pending <= is_word;  // a pixel word needs two bytes.
        end else if (byte_done) begin
            if (second_pending) begin
                second_pending <= 1'b0;  // low byte goes out next.
            end else begin
                busy <= 1'b0;
            end
        end
    end

    // out_byte stays stable while busy because entry_q only loads when idle
    // and second_pending only moves on a completed transfer.

endmodule

`default_nettype wire

//--- spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_lcd_defs.svh"

module spi_master (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire spi_bus_pkg::spi_byte_t in_byte,
    input  wire                         in_valid,
    output logic                        in_ready,
    output spi_bus_pkg::spi_pins_t      pins
);

    localparam bit CPOL  = `SPI_CPOL;
    localparam bit CPHA  = `SPI_CPHA;
    localparam int DIV   = `SPI_CLK_DIV;
    localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

    typedef enum logic [3:0] {
        ST_IDLE = 4'b0001,  // cs_n high and nothing queued.
        ST_SEND = 4'b0010,  // sixteen sclk edges of one byte.
        ST_DONE = 4'b0100,  // trailing half period after the last edge.
        ST_WAIT = 4'b1000   // next byte loaded, finishing the half period.
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;       // one pulse per sclk half period.
    logic [3:0]       bit_cnt;    // counts sclk edges within a byte.
    logic [7:0]       shift_reg;
    logic             dc_reg;
    logic             sclk_reg;
    logic             accept;
    logic             shift_edge;
    logic             last_edge;

    assign accept    = in_valid && in_ready;
    assign tick      = (state != ST_IDLE) && (div_cnt == DIV_W'(DIV - 1));
    assign last_edge = (bit_cnt == 4'd15);

    // bit_cnt holds the index of the edge about to happen.
    // cpha 0 samples on even edges and shifts on odd ones.
    // cpha 1 shows the msb at the first edge and shifts on the later even edges.
    assign shift_edge = CPHA ? (!bit_cnt[0] && (bit_cnt != 4'd0)) : bit_cnt[0];

    // ready only while idle or in the trailing half period.
    assign in_ready = (state == ST_IDLE) || (state == ST_DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (in_valid) begin
                    state_nxt = ST_SEND;  // cs_n falls together with the load.
                end
            end
            ST_SEND: begin
                if (tick && last_edge) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                if (in_valid) begin
                    state_nxt = tick ? ST_SEND : ST_WAIT;  // back-to-back keeps cs_n low.
                end else if (tick) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_WAIT: begin
                if (tick) begin
                    state_nxt = ST_SEND;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            div_cnt <= '0;
        end else begin
            state <= state_nxt;
            if ((state == ST_IDLE) || tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // sixteen toggles bring sclk back to cpol, and bit_cnt wraps to zero with them.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            sclk_reg <= CPOL;
        end else if ((state == ST_SEND) && tick) begin
            bit_cnt  <= bit_cnt + 4'd1;
            sclk_reg <= ~sclk_reg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= '0;
            dc_reg    <= 1'b0;
        end else if (accept) begin
            shift_reg <= in_byte.data;
            dc_reg    <= in_byte.dc;  // held until the next byte is taken.
        end else if ((state == ST_SEND) && tick && shift_edge) begin
            shift_reg <= {shift_reg[6:0], 1'b0};  // msb first.
        end
    end

    assign pins.cs_n = (state == ST_IDLE);
    assign pins.sclk = sclk_reg;
    assign pins.mosi = shift_reg[7];
    assign pins.dc   = dc_reg;

endmodule

`default_nettype wire

//--- lcd_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_lcd_defs.svh"

module lcd_spi_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire lcd_entry_pkg::lcd_entry_t in_entry,
    input  wire                            in_valid,
    output logic                           in_ready,
    output spi_bus_pkg::spi_pins_t         pins
);

    lcd_entry_pkg::lcd_entry_t fifo_entry;
    logic                      fifo_entry_valid;
    logic                      fifo_entry_ready;
    spi_bus_pkg::spi_byte_t    ser_byte;
    logic                      ser_valid;
    logic                      ser_ready;
    spi_bus_pkg::spi_byte_t    fifo_byte;
    logic                      fifo_byte_valid;
    logic                      fifo_byte_ready;

    stream_fifo #(
        .payload_t (lcd_entry_pkg::lcd_entry_t),
        .DEPTH     (`ENTRY_FIFO_DEPTH)
    ) u_entry_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_entry),
        .in_valid  (in_valid),
        .in_ready  (in_ready),  // host sees back-pressure here.
        .out_data  (fifo_entry),
        .out_valid (fifo_entry_valid),
        .out_ready (fifo_entry_ready)
    );

    entry_serializer u_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_entry  (fifo_entry),
        .in_valid  (fifo_entry_valid),
        .in_ready  (fifo_entry_ready),
        .out_byte  (ser_byte),
        .out_valid (ser_valid),
        .out_ready (ser_ready)
    );

    stream_fifo #(
        .payload_t (spi_bus_pkg::spi_byte_t),
        .DEPTH     (`BYTE_FIFO_DEPTH)
    ) u_byte_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (ser_byte),
        .in_valid  (ser_valid),
        .in_ready  (ser_ready),
        .out_data  (fifo_byte),
        .out_valid (fifo_byte_valid),
        .out_ready (fifo_byte_ready)
    );

    spi_master u_spi_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_byte  (fifo_byte),
        .in_valid (fifo_byte_valid),
        .in_ready (fifo_byte_ready),
        .pins     (pins)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD  = 20,  // ns, one clock is 40 ns.
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #1 rst_n = 1'b1;  // released just after an edge.
    end

endmodule

`default_nettype wire

//--- tb_lcd_spi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_spi;

    localparam int WAIT_LIMIT  = 2000;   // clocks one entry may wait for in_ready.
    localparam int DRAIN_LIMIT = 20000;  // clocks for the whole stream to leave.
    localparam int QUIET_LIMIT = 200;    // clocks cs_n stays high once the stream is done.

    logic                      clk;
    logic                      rst_n;
    lcd_entry_pkg::lcd_entry_t in_entry;
    logic                      in_valid;
    logic                      in_ready;
    spi_bus_pkg::spi_pins_t    pins;

    lcd_entry_pkg::lcd_entry_t entry_q[$];
    bit                        gap_q[$];  // 1 puts random idle cycles after the entry.
    spi_bus_pkg::spi_byte_t    expect_q[$];
    int                        expect_total;
    int                        rx_count = 0;
    bit                        saw_full = 1'b0;

    tb_clkgen #(.HALF_PERIOD(20), .RESET_CYCLES(3)) u_clkgen (.clk(clk), .rst_n(rst_n));

    lcd_spi_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_entry (in_entry),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .pins     (pins)
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int unsigned exp_val,
                                   input int unsigned act_val);
        stop_run($sformatf("FAIL at %0d ns: %s expected 0x%0h, got 0x%0h",
                           $time, name, exp_val, act_val));
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            waited++;
            if (waited > 100) begin
                stop_run("reset was never released");
            end
            @(posedge clk);
        end
    endtask

    // E lines are host entries, B lines the bytes expected on the wire.
    task automatic load_stimulus();
        int                        fd;
        int                        k;
        int                        p;
        int                        f;
        string                     tag;
        string                     line;
        lcd_entry_pkg::lcd_entry_t e;
        spi_bus_pkg::spi_byte_t    b;
        fd = $fopen("lcd_spi_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("could not open lcd_spi_stimulus.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                void'($fgets(line, fd));  // rest of a comment line.
            end else if (tag == "E" && $fscanf(fd, "%h %h %h", k, p, f) == 3) begin
                e.kind    = lcd_entry_pkg::entry_kind_t'(k[1:0]);
                e.payload = p[15:0];
                entry_q.push_back(e);
                gap_q.push_back(f[0]);
            end else if (tag == "B" && $fscanf(fd, "%h %h", f, p) == 2) begin
                b.dc   = f[0];
                b.data = p[7:0];
                expect_q.push_back(b);
            end else begin
                stop_run("malformed line in lcd_spi_stimulus.txt");
            end
        end
        $fclose(fd);
    endtask

    // holds the entry until the dut takes it. in_ready is looked at mid cycle.
    task automatic send_entry(input lcd_entry_pkg::lcd_entry_t e);
        int waited;
        waited   = 0;
        in_entry = e;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            saw_full = 1'b1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("in_ready stayed low and the entry was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);  // transfer edge.
        #1;
        in_valid = 1'b0;
    endtask

    // pins are sampled between clock edges. bits are taken where sclk has just risen.
    initial begin
        logic                   last_sclk;
        logic                   last_cs_n;
        logic [7:0]             shift;
        int                     bits;
        spi_bus_pkg::spi_byte_t exp_byte;
        bits  = 0;
        shift = '0;
        wait_reset_release();
        last_sclk = pins.sclk;
        last_cs_n = pins.cs_n;
        forever begin
            @(negedge clk);
            if (pins.sclk != last_sclk) begin
                assert (!pins.cs_n) else stop_run("sclk toggled while cs_n was high");
                if (pins.sclk) begin
                    shift = {shift[6:0], pins.mosi};  // msb arrives first.
                    bits++;
                end
            end
            if (bits == 8) begin
                assert (expect_q.size() > 0) else stop_run("more bytes on the wire than expected");
                exp_byte = expect_q.pop_front();
                assert (shift == exp_byte.data)
                    else report_mismatch("mosi byte", 32'(exp_byte.data), 32'(shift));
                assert (pins.dc == exp_byte.dc)
                    else report_mismatch("dc", 32'(exp_byte.dc), 32'(pins.dc));
                rx_count++;
                bits = 0;
            end
            if (pins.cs_n && !last_cs_n) begin
                assert (bits == 0) else stop_run("cs_n rose in the middle of a byte");
            end
            last_sclk = pins.sclk;
            last_cs_n = pins.cs_n;
        end
    end

    initial begin
        lcd_entry_pkg::lcd_entry_t e;
        int unsigned               idle;
        int                        waited;
        int                        quiet;
        in_valid = 1'b0;
        in_entry = '0;
        void'($urandom(74157));
        load_stimulus();
        expect_total = expect_q.size();
        wait_reset_release();
        @(negedge clk);
        assert (pins.cs_n == 1'b1) else report_mismatch("cs_n", 1, 32'(pins.cs_n));
        assert (pins.sclk == 1'b0) else report_mismatch("sclk", 0, 32'(pins.sclk));
        assert (pins.dc == 1'b0) else report_mismatch("dc", 0, 32'(pins.dc));
        assert (in_ready == 1'b1) else report_mismatch("in_ready", 1, 32'(in_ready));
        @(posedge clk);
        #1;
        while (entry_q.size() > 0) begin
            e = entry_q.pop_front();
            send_entry(e);
            if (gap_q.pop_front()) begin
                idle = ($urandom % 4 == 0) ? 0 : $urandom % 21;  // some gaps are empty.
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        // the stream has drained once cs_n stays high for a while.
        waited = 0;
        quiet  = 0;
        while (quiet < QUIET_LIMIT) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_run("the stream did not drain and cs_n never returned high");
            end
            @(negedge clk);
            if (pins.cs_n) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        assert (rx_count == expect_total)
            else report_mismatch("byte count", expect_total, rx_count);
        assert (saw_full) else stop_run("in_ready never dropped during the burst");
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- lcd_spi_stimulus.txt
# E kind payload gap : kind 0 cmd, 1 data8, 2 data16, gap 1 adds random idle cycles
# B dc byte : next byte expected on mosi with its dc level
E 0 002a 1
E 1 a53c 1
E 2 f81f 1
E 0 002c 0
E 2 1234 0
E 2 5678 0
E 2 9abc 0
E 2 def0 0
E 2 0f0f 0
E 2 a5c3 0
B 0 2a
B 1 3c
B 1 f8
B 1 1f
B 0 2c
B 1 12
B 1 34
B 1 56
B 1 78
B 1 9a
B 1 bc
B 1 de
B 1 f0
B 1 0f
B 1 0f
B 1 a5
B 1 c3

//--- flist.f
+incdir+.
lcd_entry_pkg.sv
spi_bus_pkg.sv
stream_fifo.sv
entry_serializer.sv
spi_master.sv
lcd_spi_top.sv
tb_clkgen.sv
tb_lcd_spi.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_lcd_spi -o sim_lcd_spi
out=$(./obj_dir/sim_lcd_spi 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
